// File: hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // window geometry, fixed by the datapath
  localparam int WIN_SIZE = 7;
  localparam int WIN_HALF = 3;

  // width of row and column counters
  localparam int POS_W = 10;

  typedef logic [7:0] pix_t;

  // one vertical slice of the window, row0 is the oldest image row
  typedef struct packed {
    pix_t row0;
    pix_t row1;
    pix_t row2;
    pix_t row3;
    pix_t row4;
    pix_t row5;
    pix_t row6;
  } win_col_t;

  // index 0 holds the oldest column
  typedef win_col_t [WIN_SIZE-1:0] win_t;

  // 49 * 255 fits in 14 bits
  typedef logic [13:0] sum_t;

  typedef struct packed {
    logic [POS_W-1:0] row;
    logic [POS_W-1:0] col;
  } pos_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_FLUSH
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/pixel_line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_line_buffer #(
  parameter int IMG_W = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              shift_en_i,
  input  conv_pkg::pix_t    pix_i,
  output conv_pkg::win_col_t col_o
);

  // six full image rows of history
  localparam int DEPTH = (conv_pkg::WIN_SIZE - 1) * IMG_W;

  // sr_q[0] is the previous pixel, sr_q[n] is n+1 pixels back
  conv_pkg::pix_t [DEPTH-1:0] sr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sr_q <= '0;
    end else if (shift_en_i) begin
      sr_q <= {sr_q[DEPTH-2:0], pix_i};
    end
  end

  // tap every IMG_W pixels, newest on row6
  always_comb begin
    col_o.row6 = pix_i;
    col_o.row5 = sr_q[1*IMG_W-1];
    col_o.row4 = sr_q[2*IMG_W-1];
    col_o.row3 = sr_q[3*IMG_W-1];
    col_o.row2 = sr_q[4*IMG_W-1];
    col_o.row1 = sr_q[5*IMG_W-1];
    col_o.row0 = sr_q[6*IMG_W-1];
  end

endmodule

`default_nettype wire

// File: hdl/window_7x7_pad.sv
`timescale 1ns/1ns
`default_nettype none

module window_7x7_pad #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               shift_en_i,
  input  logic               emit_en_i,
  input  logic               last_i,
  input  conv_pkg::win_col_t col_i,
  input  conv_pkg::pos_t     centre_i,
  output conv_pkg::win_t     masked_o,
  output logic               win_valid_o,
  output logic               win_last_o
);

  localparam int HALF = conv_pkg::WIN_HALF;
  localparam int SIZE = conv_pkg::WIN_SIZE;

  conv_pkg::win_t win_q;
  conv_pkg::win_t win_next;
  conv_pkg::win_t masked_next;

  // centre within d taps of each border
  logic [HALF:1] row_lo;
  logic [HALF:1] row_hi;
  logic [HALF:1] col_lo;
  logic [HALF:1] col_hi;

  logic [SIZE-1:0] row_ok;
  logic [SIZE-1:0] col_ok;

  // the new column enters on the high side
  assign win_next = {col_i, win_q[SIZE-1:1]};

  always_ff @(posedge clk) begin
    if (shift_en_i) begin
      win_q <= win_next;
    end
  end

  always_comb begin
    for (int d = 1; d <= HALF; d++) begin
      row_lo[d] = int'(centre_i.row) < d;
      row_hi[d] = int'(centre_i.row) > IMG_H - 1 - d;
      col_lo[d] = int'(centre_i.col) < d;
      col_hi[d] = int'(centre_i.col) > IMG_W - 1 - d;
    end
  end

  // tap k sits at offset k - HALF from the centre
  always_comb begin
    for (int k = 0; k < SIZE; k++) begin
      if (k < HALF) begin
        row_ok[k] = !row_lo[HALF-k];
        col_ok[k] = !col_lo[HALF-k];
      end else if (k > HALF) begin
        row_ok[k] = !row_hi[k-HALF];
        col_ok[k] = !col_hi[k-HALF];
      end else begin
        row_ok[k] = 1'b1;
        col_ok[k] = 1'b1;
      end
    end
  end

  // the window seen by the mask already includes this cycle's column
  always_comb begin
    conv_pkg::pix_t [0:SIZE-1] taps;
    for (int j = 0; j < SIZE; j++) begin
      taps = win_next[j];
      for (int k = 0; k < SIZE; k++) begin
        if (!(row_ok[k] && col_ok[j])) begin
          taps[k] = '0;
        end
      end
      masked_next[j] = taps;
    end
  end

  always_ff @(posedge clk) begin
    if (emit_en_i) begin
      masked_o <= masked_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= emit_en_i;
      win_last_o  <= emit_en_i && last_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/window_sum_tree.sv
`timescale 1ns/1ns
`default_nettype none

module window_sum_tree (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           win_valid_i,
  input  logic           win_last_i,
  input  conv_pkg::win_t win_i,
  output logic           sum_valid_o,
  output conv_pkg::sum_t sum_o,
  output logic           frame_done_o
);

  localparam int SIZE = conv_pkg::WIN_SIZE;

  // 7 * 255 needs 11 bits
  localparam int PART_W = 11;

  logic [SIZE-1:0][PART_W-1:0] part_q;
  logic                        part_valid_q;
  logic                        part_last_q;

  function automatic logic [PART_W-1:0] col_sum(conv_pkg::win_col_t c);
    col_sum = PART_W'(c.row0) + PART_W'(c.row1) + PART_W'(c.row2)
            + PART_W'(c.row3) + PART_W'(c.row4) + PART_W'(c.row5)
            + PART_W'(c.row6);
  endfunction

  // stage one, one partial per column
  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      for (int j = 0; j < SIZE; j++) begin
        part_q[j] <= col_sum(win_i[j]);
      end
    end
  end

  // stage two
  always_ff @(posedge clk) begin
    if (part_valid_q) begin
      sum_o <= conv_pkg::sum_t'(part_q[0]) + conv_pkg::sum_t'(part_q[1])
             + conv_pkg::sum_t'(part_q[2]) + conv_pkg::sum_t'(part_q[3])
             + conv_pkg::sum_t'(part_q[4]) + conv_pkg::sum_t'(part_q[5])
             + conv_pkg::sum_t'(part_q[6]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      part_valid_q <= 1'b0;
      part_last_q  <= 1'b0;
      sum_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      part_valid_q <= win_valid_i;
      part_last_q  <= win_valid_i && win_last_i;
      sum_valid_o  <= part_valid_q;
      frame_done_o <= part_last_q;
    end
  end

endmodule

`default_nettype wire

// File: hdl/window_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module window_ctrl #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pix_valid_i,
  input  conv_pkg::pix_t   pix_i,
  output logic             pix_ready_o,
  output logic             shift_en_o,
  output logic             emit_en_o,
  output conv_pkg::pix_t   in_pix_o,
  output conv_pkg::pos_t   centre_o,
  output logic             last_o
);

  localparam int PW        = conv_pkg::POS_W;
  localparam int FRAME_PIX = IMG_W * IMG_H;
  // input runs this many pixels ahead of the centre
  localparam int LEAD      = conv_pkg::WIN_HALF * IMG_W + conv_pkg::WIN_HALF;
  localparam int TOTAL     = FRAME_PIX + LEAD;
  localparam int CNT_W     = $clog2(TOTAL + 1);

  conv_pkg::ctrl_state_e state_q;
  logic [CNT_W-1:0]      in_cnt_q;
  conv_pkg::pos_t        centre_q;

  logic flushing;

  assign flushing    = state_q == conv_pkg::CTRL_FLUSH;
  assign pix_ready_o = !flushing;

  // flush pushes zero pixels without waiting for input
  assign shift_en_o = flushing || (pix_valid_i && pix_ready_o);
  assign in_pix_o   = flushing ? '0 : pix_i;
  assign emit_en_o  = shift_en_o && (in_cnt_q >= CNT_W'(LEAD));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= conv_pkg::CTRL_IDLE;
      in_cnt_q <= '0;
    end else if (shift_en_o) begin
      case (state_q)
        conv_pkg::CTRL_FLUSH: begin
          if (in_cnt_q == CNT_W'(TOTAL - 1)) begin
            state_q  <= conv_pkg::CTRL_IDLE;
            in_cnt_q <= '0;
          end else begin
            in_cnt_q <= in_cnt_q + 1'b1;
          end
        end
        default: begin
          in_cnt_q <= in_cnt_q + 1'b1;
          if (in_cnt_q == CNT_W'(FRAME_PIX - 1)) begin
            state_q <= conv_pkg::CTRL_FLUSH;
          end else begin
            state_q <= conv_pkg::CTRL_RUN;
          end
        end
      endcase
    end
  end

  // centre position, column first then row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      centre_q <= '0;
    end else if (emit_en_o) begin
      if (centre_q.col == PW'(IMG_W - 1)) begin
        centre_q.col <= '0;
        if (centre_q.row == PW'(IMG_H - 1)) begin
          centre_q.row <= '0;
        end else begin
          centre_q.row <= centre_q.row + 1'b1;
        end
      end else begin
        centre_q.col <= centre_q.col + 1'b1;
      end
    end
  end

  assign centre_o = centre_q;
  assign last_o   = (centre_q.row == PW'(IMG_H - 1)) && (centre_q.col == PW'(IMG_W - 1));

endmodule

`default_nettype wire

// File: hdl/box_filter_top.sv
`timescale 1ns/1ns
`default_nettype none

module box_filter_top #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           pix_valid_i,
  input  conv_pkg::pix_t pix_i,
  output logic           pix_ready_o,
  output logic           sum_valid_o,
  output conv_pkg::sum_t sum_o,
  output logic           frame_done_o
);

  logic               shift_en;
  logic               emit_en;
  logic               last;
  conv_pkg::pix_t     in_pix;
  conv_pkg::pos_t     centre;
  conv_pkg::win_col_t col;
  conv_pkg::win_t     masked;
  logic               win_valid;
  logic               win_last;

  window_ctrl #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid_i(pix_valid_i),
    .pix_i      (pix_i),
    .pix_ready_o(pix_ready_o),
    .shift_en_o (shift_en),
    .emit_en_o  (emit_en),
    .in_pix_o   (in_pix),
    .centre_o   (centre),
    .last_o     (last)
  );

  pixel_line_buffer #(
    .IMG_W(IMG_W)
  ) u_line_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .shift_en_i(shift_en),
    .pix_i     (in_pix),
    .col_o     (col)
  );

  window_7x7_pad #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en_i (shift_en),
    .emit_en_i  (emit_en),
    .last_i     (last),
    .col_i      (col),
    .centre_i   (centre),
    .masked_o   (masked),
    .win_valid_o(win_valid),
    .win_last_o (win_last)
  );

  window_sum_tree u_tree (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_valid_i (win_valid),
    .win_last_i  (win_last),
    .win_i       (masked),
    .sum_valid_o (sum_valid_o),
    .sum_o       (sum_o),
    .frame_done_o(frame_done_o)
  );

endmodule

`default_nettype wire

// File: sim/box_filter_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module box_filter_assertions #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input logic clk,
  input logic rst_n,
  input logic pix_valid_i,
  input logic pix_ready_i,
  input logic sum_valid_i,
  input logic frame_done_i
);

  localparam int FRAME = IMG_W * IMG_H;
  localparam int FLUSH = conv_pkg::WIN_HALF * IMG_W + conv_pkg::WIN_HALF;

  int acc_cnt;
  int low_left;

  // count of failed assertions
  int fail_cnt = 0;

  // pixels taken in this frame, and flush cycles still to come
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_cnt  <= 0;
      low_left <= 0;
    end else begin
      if (low_left > 0) begin
        low_left <= low_left - 1;
      end
      if (pix_valid_i && pix_ready_i) begin
        if (acc_cnt == FRAME - 1) begin
          acc_cnt  <= 0;
          low_left <= FLUSH;
        end else begin
          acc_cnt <= acc_cnt + 1;
        end
      end
    end
  end

  no_early_sum: assert property (@(posedge clk)
    (rst_n && (!$past(rst_n) || !$past(rst_n, 2))) |-> !sum_valid_i)
    else begin
      $error("sum_valid_o high just after reset release");
      fail_cnt++;
    end

  done_with_sum: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done_i |-> sum_valid_i)
    else begin
      $error("frame_done_o high without sum_valid_o");
      fail_cnt++;
    end

  ready_low_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    (low_left != 0) |-> !pix_ready_i)
    else begin
      $error("pix_ready_o high during flush");
      fail_cnt++;
    end

  ready_high_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
    (low_left == 0) |-> pix_ready_i)
    else begin
      $error("pix_ready_o low outside flush");
      fail_cnt++;
    end

endmodule

bind box_filter_top box_filter_assertions #(
  .IMG_W(IMG_W),
  .IMG_H(IMG_H)
) u_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .pix_valid_i (pix_valid_i),
  .pix_ready_i (pix_ready_o),
  .sum_valid_i (sum_valid_o),
  .frame_done_i(frame_done_o)
);

`default_nettype wire

// File: sim/box_filter_checker.sv
`timescale 1ns/1ns
`default_nettype none

module box_filter_checker #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 10
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           pix_valid_i,
  input  conv_pkg::pix_t pix_i,
  input  logic           pix_ready_i,
  input  logic           sum_valid_i,
  input  conv_pkg::sum_t sum_i,
  input  logic           frame_done_i,
  output int             err_cnt_o,
  output int             sum_cnt_o,
  output int             frame_cnt_o
);

  localparam int FRAME = IMG_W * IMG_H;
  localparam int HALF  = conv_pkg::WIN_HALF;
  // ready is low while the frame tail is flushed
  localparam int FLUSH = HALF * IMG_W + HALF;

  // two images, the next frame may start before the last sums leave
  conv_pkg::pix_t img [2][FRAME];

  int in_frame;
  int in_idx;
  int out_frame;
  int out_idx;
  int flush_left;

  // 7x7 neighbourhood sum, pixels outside the image count as zero
  function automatic int padded_sum(int slot, int r, int c);
    int acc;
    int rr;
    int cc;
    acc = 0;
    for (int dr = -HALF; dr <= HALF; dr++) begin
      for (int dc = -HALF; dc <= HALF; dc++) begin
        rr = r + dr;
        cc = c + dc;
        if (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W) begin
          acc += int'(img[slot][rr * IMG_W + cc]);
        end
      end
    end
    return acc;
  endfunction

  always @(posedge clk) begin
    int exp_sum;
    int need;
    int r;
    int c;
    logic last_sum;
    if (!rst_n) begin
      in_frame    = 0;
      in_idx      = 0;
      out_frame   = 0;
      out_idx     = 0;
      flush_left  = 0;
      err_cnt_o   = 0;
      sum_cnt_o   = 0;
      frame_cnt_o = 0;
    end else begin
      if (pix_ready_i !== (flush_left == 0)) begin
        $display("CHECK FAILED pix_ready_o: got 0x%h expected 0x%h",
                 pix_ready_i, flush_left == 0);
        err_cnt_o++;
      end
      if (flush_left > 0) begin
        flush_left--;
      end
      if (pix_valid_i && pix_ready_i) begin
        img[in_frame % 2][in_idx] = pix_i;
        if (in_idx == FRAME - 1) begin
          in_idx     = 0;
          in_frame++;
          flush_left = FLUSH;
        end else begin
          in_idx++;
        end
      end
      if (frame_done_i && !sum_valid_i) begin
        $display("frame_done_o pulsed without sum_valid_o");
        err_cnt_o++;
      end
      if (sum_valid_i) begin
        r    = out_idx / IMG_W;
        c    = out_idx % IMG_W;
        // newest input pixel that this centre depends on
        need = (out_idx + FLUSH < FRAME) ? out_idx + FLUSH : FRAME - 1;
        if (in_frame < out_frame || (in_frame == out_frame && in_idx <= need)) begin
          $display("sum for centre (%0d,%0d) came out before its pixels were accepted",
                   r, c);
          err_cnt_o++;
        end else begin
          exp_sum = padded_sum(out_frame % 2, r, c);
          if (sum_i !== conv_pkg::sum_t'(exp_sum)) begin
            $display("CHECK FAILED sum_o frame %0d centre (%0d,%0d): got 0x%h expected 0x%h",
                     out_frame, r, c, sum_i, conv_pkg::sum_t'(exp_sum));
            err_cnt_o++;
          end
        end
        last_sum = out_idx == FRAME - 1;
        if (frame_done_i !== last_sum) begin
          $display("CHECK FAILED frame_done_o frame %0d centre (%0d,%0d): got 0x%h expected 0x%h",
                   out_frame, r, c, frame_done_i, last_sum);
          err_cnt_o++;
        end
        sum_cnt_o++;
        if (last_sum) begin
          out_idx = 0;
          out_frame++;
        end else begin
          out_idx++;
        end
      end
      if (frame_done_i && sum_valid_i) begin
        frame_cnt_o++;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_box_filter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_box_filter;

  localparam int IMG_W  = 12;
  localparam int IMG_H  = 10;
  localparam int FRAME  = IMG_W * IMG_H;
  localparam int FLUSH  = conv_pkg::WIN_HALF * IMG_W + conv_pkg::WIN_HALF;
  localparam int FRAMES = 6;
  // gapped frames take up to twice their size, plus the flush tail
  localparam int LIMIT  = FRAMES * (2 * FRAME + FLUSH) + 200;

  logic           clk;
  logic           rst_n;
  logic           pix_valid;
  conv_pkg::pix_t pix;
  logic           pix_ready;
  logic           sum_valid;
  conv_pkg::sum_t sum;
  logic           frame_done;

  int     err_cnt;
  int     sum_cnt;
  int     frame_cnt;
  int     tb_errs;
  int     err_base;
  int     tb_base;
  int     asrt_base;
  int     sum_base;
  int     frame_base;
  int     total_errs;
  int     cycles = 0;
  integer seed;

  box_filter_top #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid),
    .pix_i       (pix),
    .pix_ready_o (pix_ready),
    .sum_valid_o (sum_valid),
    .sum_o       (sum),
    .frame_done_o(frame_done)
  );

  box_filter_checker #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid),
    .pix_i       (pix),
    .pix_ready_i (pix_ready),
    .sum_valid_i (sum_valid),
    .sum_i       (sum),
    .frame_done_i(frame_done),
    .err_cnt_o   (err_cnt),
    .sum_cnt_o   (sum_cnt),
    .frame_cnt_o (frame_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // kind 1 sends all 255, otherwise random pixels; a pixel is held until taken
  task automatic send_frame(input int kind, input int gap_pct, input bit hold_valid);
    int sent;
    bit have_pix;
    sent     = 0;
    have_pix = 1'b0;
    while (sent < FRAME) begin
      @(negedge clk);
      if (gap_pct > 0 && ($unsigned($random(seed)) % 100) < gap_pct) begin
        pix_valid = 1'b0;
      end else begin
        if (!have_pix) begin
          pix      = (kind == 1) ? 8'hff : conv_pkg::pix_t'($random(seed));
          have_pix = 1'b1;
        end
        pix_valid = 1'b1;
        if (pix_ready) begin
          sent++;
          have_pix = 1'b0;
        end
      end
    end
    if (!hold_valid) begin
      @(negedge clk);
      pix_valid = 1'b0;
    end
  endtask

  task automatic wait_frames(input int target);
    while (frame_cnt < target) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test();
    err_base   = err_cnt;
    tb_base    = tb_errs;
    asrt_base  = dut.u_assertions.fail_cnt;
    sum_base   = sum_cnt;
    frame_base = frame_cnt;
  endtask

  task automatic finish_test(input int num, input string name, input int frames);
    if (sum_cnt - sum_base != frames * FRAME || frame_cnt - frame_base != frames) begin
      $display("test %0d got %0d sums in %0d frames where %0d frames were sent",
               num, sum_cnt - sum_base, frame_cnt - frame_base, frames);
      tb_errs++;
    end
    $display("test %0d %s: %0d sums, %0d frames, %0d errors", num, name,
             sum_cnt - sum_base, frame_cnt - frame_base,
             (err_cnt - err_base) + (tb_errs - tb_base)
             + (dut.u_assertions.fail_cnt - asrt_base));
  endtask

  initial begin
    seed      = 32'hfcdd;
    rst_n     = 1'b0;
    pix_valid = 1'b0;
    pix       = '0;
    tb_errs   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    repeat (20) @(negedge clk);
    finish_test(1, "idle after reset", 0);

    start_test();
    send_frame(0, 0, 1'b0);
    wait_frames(frame_base + 1);
    finish_test(2, "random frame", 1);

    start_test();
    send_frame(1, 0, 1'b0);
    wait_frames(frame_base + 1);
    finish_test(3, "all 255 frame", 1);

    start_test();
    send_frame(0, 30, 1'b0);
    wait_frames(frame_base + 1);
    finish_test(4, "random frame with gaps", 1);

    // valid stays high through each flush
    start_test();
    send_frame(0, 0, 1'b1);
    send_frame(0, 0, 1'b1);
    send_frame(0, 0, 1'b0);
    wait_frames(frame_base + 3);
    repeat (10) @(negedge clk);
    finish_test(5, "back to back frames", 3);

    total_errs = err_cnt + tb_errs + dut.u_assertions.fail_cnt;
    $display("summary: 5 tests, %0d sums, %0d frames, %0d errors",
             sum_cnt, frame_cnt, total_errs);
    if (total_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hdl/conv_pkg.sv
hdl/pixel_line_buffer.sv
hdl/window_7x7_pad.sv
hdl/window_sum_tree.sv
hdl/window_ctrl.sv
hdl/box_filter_top.sv
sim/box_filter_assertions.sv
sim/box_filter_checker.sv
sim/tb_box_filter.sv

// File: run.sh
#!/bin/sh
# build and run the box filter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_box_filter -f src.f -o Vtb_box_filter \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_box_filter > sim.log 2>&1 \
  || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
